// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [3:0]  regno_t;
    typedef logic [15:0] imm_t;
    typedef logic [5:0]  op1_t;
    typedef logic [7:0]  op2_t;
    typedef logic [23:0] hex_t;
    typedef logic [9:0]  led_t;
    typedef logic [3:0]  key_t;

    // Source of the value written back to the register file
    typedef enum logic [1:0] {
        WB_PC,
        WB_MEM,
        WB_ALU
    } wb_src_t;

    // Primary opcodes
    localparam op1_t OP1_ALUR = 6'b000000;
    localparam op1_t OP1_BEQ  = 6'b001000;
    localparam op1_t OP1_BLT  = 6'b001001;
    localparam op1_t OP1_BLE  = 6'b001010;
    localparam op1_t OP1_BNE  = 6'b001011;
    localparam op1_t OP1_JAL  = 6'b001100;
    localparam op1_t OP1_LW   = 6'b010010;
    localparam op1_t OP1_SW   = 6'b011010;
    localparam op1_t OP1_ADDI = 6'b100000;
    localparam op1_t OP1_ANDI = 6'b100100;
    localparam op1_t OP1_ORI  = 6'b100101;
    localparam op1_t OP1_XORI = 6'b100110;

    // Secondary opcodes, ALUR only
    localparam op2_t OP2_EQ   = 8'b00001000;
    localparam op2_t OP2_LT   = 8'b00001001;
    localparam op2_t OP2_LE   = 8'b00001010;
    localparam op2_t OP2_NE   = 8'b00001011;
    localparam op2_t OP2_ADD  = 8'b00100000;
    localparam op2_t OP2_AND  = 8'b00100100;
    localparam op2_t OP2_OR   = 8'b00100101;
    localparam op2_t OP2_XOR  = 8'b00100110;
    localparam op2_t OP2_SUB  = 8'b00101000;
    localparam op2_t OP2_NAND = 8'b00101100;
    localparam op2_t OP2_NOR  = 8'b00101101;
    localparam op2_t OP2_NXOR = 8'b00101110;
    localparam op2_t OP2_RSHF = 8'b00110000;
    localparam op2_t OP2_LSHF = 8'b00110001;

    localparam word_t START_PC  = 32'h0000_0100;
    localparam word_t INST_SIZE = 32'd4;

    // Memory-mapped I/O
    localparam word_t ADDR_HEX  = 32'hFFFF_F000;
    localparam word_t ADDR_LEDR = 32'hFFFF_F020;
    localparam word_t ADDR_KEY  = 32'hFFFF_F080;

    localparam int IMEM_WORDS   = 16384;
    localparam int DMEM_WORDS   = 16384;
    localparam int MEM_WORD_LSB = 2;  // Byte offset bits dropped
    localparam int MEM_ADDR_MSB = 15;

endpackage

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  stall,
    input  logic  redirect,
    input  word_t target,
    output inst_t inst,
    output word_t pc_next
);

    word_t pc;
    word_t pc_plus;
    inst_t imem_word;

    inst_t imem [IMEM_WORDS];

    initial begin
        $readmemh("test.hex", imem);
    end

    assign pc_plus   = pc + INST_SIZE;
    assign imem_word = imem[pc[MEM_ADDR_MSB:MEM_WORD_LSB]];

    // Redirect wins over stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc   <= START_PC;
            inst <= '0;                 // All-zero word decodes as a bubble
        end else if (redirect) begin
            pc   <= target;
            inst <= '0;
        end else if (!stall) begin
            pc   <= pc_plus;
            inst <= imem_word;
        end
    end

    // Return address travels with its instruction
    always_ff @(posedge clk) begin
        if (!stall || redirect) begin
            pc_next <= pc_plus;
        end
    end

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  inst_t   inst,
    input  word_t   pc_in,
    input  logic    redirect,
    input  regno_t  ex_dst,
    input  regno_t  mem_dst,
    input  logic    ex_reg_we,
    input  logic    mem_reg_we,
    input  logic    wb_we,
    input  regno_t  wb_dst,
    input  word_t   wb_val,
    output logic    stall,
    output op1_t    op1,
    output op2_t    op2,
    output word_t   rs_val,
    output word_t   rt_val,
    output word_t   imm_sx,
    output word_t   pc_next,
    output regno_t  dst,
    output logic    reg_we,
    output logic    mem_we,
    output logic    mem_re,
    output wb_src_t wb_src
);

    op1_t    op1_d;
    op2_t    op2_d;
    imm_t    imm_d;
    regno_t  rd_d;
    regno_t  rs_d;
    regno_t  rt_d;
    logic    valid_d;
    logic    is_br_d;
    logic    is_imm_d;
    logic    rt_used_d;
    logic    reg_we_d;
    regno_t  dst_d;
    wb_src_t wb_src_d;
    word_t   rs_rd;
    word_t   rt_rd;

    word_t regs [16];

    assign op1_d = inst[31:26];
    assign op2_d = inst[25:18];
    assign imm_d = inst[23:8];
    assign rd_d  = inst[11:8];
    assign rs_d  = inst[7:4];
    assign rt_d  = inst[3:0];

    assign valid_d   = (inst != '0);
    assign is_br_d   = (op1_d == OP1_BEQ) || (op1_d == OP1_BLT) ||
                       (op1_d == OP1_BLE) || (op1_d == OP1_BNE);
    assign is_imm_d  = (op1_d == OP1_ADDI) || (op1_d == OP1_ANDI) ||
                       (op1_d == OP1_ORI)  || (op1_d == OP1_XORI);
    assign rt_used_d = (op1_d == OP1_ALUR) || is_br_d || (op1_d == OP1_SW);
    assign reg_we_d  = valid_d && ((op1_d == OP1_ALUR) || (op1_d == OP1_JAL) ||
                                   (op1_d == OP1_LW) || is_imm_d);
    assign dst_d     = (op1_d == OP1_ALUR) ? rd_d : rt_d;

    always_comb begin
        if (op1_d == OP1_JAL) begin
            wb_src_d = WB_PC;
        end else if (op1_d == OP1_LW) begin
            wb_src_d = WB_MEM;
        end else begin
            wb_src_d = WB_ALU;
        end
    end

    // Register in flight in any later stage
    function automatic logic pending(input regno_t r);
        return (reg_we && dst == r) || (ex_reg_we && ex_dst == r) ||
               (mem_reg_we && mem_dst == r);
    endfunction

    assign stall = ((rs_d != '0) && pending(rs_d)) ||
                   (rt_used_d && (rt_d != '0) && pending(rt_d));

    // Reads see a write landing in the same cycle
    assign rs_rd = (rs_d == '0) ? '0 :
                   (wb_we && wb_dst == rs_d) ? wb_val : regs[rs_d];
    assign rt_rd = (rt_d == '0) ? '0 :
                   (wb_we && wb_dst == rt_d) ? wb_val : regs[rt_d];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;          // Registers start at zero
            end
        end else if (wb_we && wb_dst != '0) begin
            regs[wb_dst] <= wb_val;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op1    <= OP1_ALUR;
            dst    <= '0;
            reg_we <= 1'b0;
            mem_we <= 1'b0;
            mem_re <= 1'b0;
            wb_src <= WB_ALU;
        end else if (redirect || stall) begin
            op1    <= OP1_ALUR;         // Bubble, never branches
            reg_we <= 1'b0;
            mem_we <= 1'b0;
            mem_re <= 1'b0;
        end else begin
            op1    <= op1_d;
            dst    <= dst_d;
            reg_we <= reg_we_d;
            mem_we <= valid_d && (op1_d == OP1_SW);
            mem_re <= valid_d && (op1_d == OP1_LW);
            wb_src <= wb_src_d;
        end
    end

    always_ff @(posedge clk) begin
        op2     <= op2_d;
        rs_val  <= rs_rd;
        rt_val  <= rt_rd;
        imm_sx  <= {{16{imm_d[15]}}, imm_d};
        pc_next <= pc_in;
    end

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  op1_t    op1,
    input  op2_t    op2,
    input  word_t   rs_val,
    input  word_t   rt_val,
    input  word_t   imm_sx,
    input  word_t   pc_in,
    input  regno_t  dst_in,
    input  logic    reg_we_in,
    input  logic    mem_we_in,
    input  logic    mem_re,
    input  wb_src_t wb_src_in,
    output logic    redirect,
    output word_t   target,
    output regno_t  ex_dst,
    output logic    ex_reg_we,
    output word_t   alu_out,
    output word_t   store_val,
    output regno_t  dst,
    output logic    reg_we,
    output logic    mem_we,
    output wb_src_t wb_src,
    output word_t   pc_next
);

    logic  is_br;
    logic  is_jal;
    logic  br_cond;
    word_t alu_b;
    word_t alu_r;
    word_t offset;

    assign is_br  = (op1 == OP1_BEQ) || (op1 == OP1_BLT) ||
                    (op1 == OP1_BLE) || (op1 == OP1_BNE);
    assign is_jal = (op1 == OP1_JAL);
    assign alu_b  = (op1 == OP1_ALUR || is_br) ? rt_val : imm_sx;
    assign offset = imm_sx << 2;        // Word offset

    always_comb begin
        case (op1)
            OP1_BEQ: br_cond = (rs_val == rt_val);
            OP1_BLT: br_cond = ($signed(rs_val) <  $signed(rt_val));
            OP1_BLE: br_cond = ($signed(rs_val) <= $signed(rt_val));
            OP1_BNE: br_cond = (rs_val != rt_val);
            default: br_cond = 1'b0;
        endcase
    end

    always_comb begin
        alu_r = '0;
        if (op1 == OP1_ALUR) begin
            case (op2)
                OP2_EQ:   alu_r = {31'b0, rs_val == alu_b};
                OP2_LT:   alu_r = {31'b0, $signed(rs_val) <  $signed(alu_b)};
                OP2_LE:   alu_r = {31'b0, $signed(rs_val) <= $signed(alu_b)};
                OP2_NE:   alu_r = {31'b0, rs_val != alu_b};
                OP2_ADD:  alu_r = rs_val + alu_b;
                OP2_AND:  alu_r = rs_val & alu_b;
                OP2_OR:   alu_r = rs_val | alu_b;
                OP2_XOR:  alu_r = rs_val ^ alu_b;
                OP2_SUB:  alu_r = rs_val - alu_b;
                OP2_NAND: alu_r = ~(rs_val & alu_b);
                OP2_NOR:  alu_r = ~(rs_val | alu_b);
                OP2_NXOR: alu_r = ~(rs_val ^ alu_b);
                OP2_RSHF: alu_r = $signed(rs_val) >>> alu_b;   // Arithmetic
                OP2_LSHF: alu_r = rs_val << alu_b;
                default:  alu_r = '0;
            endcase
        end else if (mem_re || mem_we_in || op1 == OP1_ADDI) begin
            alu_r = rs_val + alu_b;     // Also the load/store address
        end else if (op1 == OP1_ANDI) begin
            alu_r = rs_val & alu_b;
        end else if (op1 == OP1_ORI) begin
            alu_r = rs_val | alu_b;
        end else if (op1 == OP1_XORI) begin
            alu_r = rs_val ^ alu_b;
        end
    end

    assign redirect = br_cond || is_jal;
    assign target   = is_jal ? rs_val + offset : pc_in + offset;

    // A taken branch leaves nothing behind; JAL still links
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dst    <= '0;
            reg_we <= 1'b0;
            mem_we <= 1'b0;
            wb_src <= WB_ALU;
        end else if (redirect && !is_jal) begin
            reg_we <= 1'b0;
            mem_we <= 1'b0;
        end else begin
            dst    <= dst_in;
            reg_we <= reg_we_in;
            mem_we <= mem_we_in;
            wb_src <= wb_src_in;
        end
    end

    always_ff @(posedge clk) begin
        alu_out   <= alu_r;
        store_val <= rt_val;
        pc_next   <= pc_in;
    end

    assign ex_dst    = dst;
    assign ex_reg_we = reg_we;

endmodule

// ==== rtl/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  key_t    key,
    input  word_t   alu_out,
    input  word_t   store_val,
    input  regno_t  dst,
    input  logic    reg_we,
    input  logic    mem_we,
    input  wb_src_t wb_src,
    input  word_t   pc_in,
    output hex_t    hex,
    output led_t    ledr,
    output regno_t  mem_dst,
    output logic    mem_reg_we,
    output logic    wb_we,
    output regno_t  wb_dst,
    output word_t   wb_val
);

    word_t load_val;
    word_t wb_sel;
    logic [MEM_ADDR_MSB-MEM_WORD_LSB:0] word_idx;

    word_t dmem [DMEM_WORDS];

    assign word_idx = alu_out[MEM_ADDR_MSB:MEM_WORD_LSB];

    // Keys are active low on the board
    assign load_val = (alu_out == ADDR_KEY) ? {{(32 - $bits(key_t)){1'b0}}, ~key}
                                            : dmem[word_idx];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            dmem[word_idx] <= store_val;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hex  <= 24'hFEDEAD;
            ledr <= '0;
        end else if (mem_we) begin
            if (alu_out == ADDR_HEX) hex <= hex_t'(store_val);
            if (alu_out == ADDR_LEDR) ledr <= led_t'(store_val);
        end
    end

    always_comb begin
        case (wb_src)
            WB_PC:   wb_sel = pc_in;    // JAL link
            WB_MEM:  wb_sel = load_val;
            default: wb_sel = alu_out;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_we  <= 1'b0;
            wb_dst <= '0;
        end else begin
            wb_we  <= reg_we;
            wb_dst <= dst;
        end
    end

    always_ff @(posedge clk) begin
        wb_val <= wb_sel;
    end

    assign mem_dst    = wb_dst;
    assign mem_reg_we = wb_we;

endmodule

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top
    import cpu_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  key_t key,
    output hex_t hex,
    output led_t ledr
);

    // Fetch to decode
    inst_t   fd_inst;
    word_t   fd_pc_next;
    logic    stall;

    // Decode to execute
    op1_t    de_op1;
    op2_t    de_op2;
    word_t   de_rs_val;
    word_t   de_rt_val;
    word_t   de_imm_sx;
    word_t   de_pc_next;
    regno_t  de_dst;
    logic    de_reg_we;
    logic    de_mem_we;
    logic    de_mem_re;
    wb_src_t de_wb_src;

    // Execute outputs
    logic    redirect;
    word_t   target;
    regno_t  ex_dst;
    logic    ex_reg_we;
    word_t   xm_alu_out;
    word_t   xm_store_val;
    regno_t  xm_dst;
    logic    xm_reg_we;
    logic    xm_mem_we;
    wb_src_t xm_wb_src;
    word_t   xm_pc_next;

    // Memory outputs, also the write-back port
    regno_t  mem_dst;
    logic    mem_reg_we;
    logic    wb_we;
    regno_t  wb_dst;
    word_t   wb_val;

    fetch_stage u_fetch (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .redirect (redirect),
        .target   (target),
        .inst     (fd_inst),
        .pc_next  (fd_pc_next)
    );

    decode_stage u_decode (
        .clk        (clk),
        .reset      (reset),
        .inst       (fd_inst),
        .pc_in      (fd_pc_next),
        .redirect   (redirect),
        .ex_dst     (ex_dst),
        .mem_dst    (mem_dst),
        .ex_reg_we  (ex_reg_we),
        .mem_reg_we (mem_reg_we),
        .wb_we      (wb_we),
        .wb_dst     (wb_dst),
        .wb_val     (wb_val),
        .stall      (stall),
        .op1        (de_op1),
        .op2        (de_op2),
        .rs_val     (de_rs_val),
        .rt_val     (de_rt_val),
        .imm_sx     (de_imm_sx),
        .pc_next    (de_pc_next),
        .dst        (de_dst),
        .reg_we     (de_reg_we),
        .mem_we     (de_mem_we),
        .mem_re     (de_mem_re),
        .wb_src     (de_wb_src)
    );

    execute_stage u_execute (
        .clk       (clk),
        .reset     (reset),
        .op1       (de_op1),
        .op2       (de_op2),
        .rs_val    (de_rs_val),
        .rt_val    (de_rt_val),
        .imm_sx    (de_imm_sx),
        .pc_in     (de_pc_next),
        .dst_in    (de_dst),
        .reg_we_in (de_reg_we),
        .mem_we_in (de_mem_we),
        .mem_re    (de_mem_re),
        .wb_src_in (de_wb_src),
        .redirect  (redirect),
        .target    (target),
        .ex_dst    (ex_dst),
        .ex_reg_we (ex_reg_we),
        .alu_out   (xm_alu_out),
        .store_val (xm_store_val),
        .dst       (xm_dst),
        .reg_we    (xm_reg_we),
        .mem_we    (xm_mem_we),
        .wb_src    (xm_wb_src),
        .pc_next   (xm_pc_next)
    );

    memory_stage u_memory (
        .clk        (clk),
        .reset      (reset),
        .key        (key),
        .alu_out    (xm_alu_out),
        .store_val  (xm_store_val),
        .dst        (xm_dst),
        .reg_we     (xm_reg_we),
        .mem_we     (xm_mem_we),
        .wb_src     (xm_wb_src),
        .pc_in      (xm_pc_next),
        .hex        (hex),
        .ledr       (ledr),
        .mem_dst    (mem_dst),
        .mem_reg_we (mem_reg_we),
        .wb_we      (wb_we),
        .wb_dst     (wb_dst),
        .wb_val     (wb_val)
    );

endmodule

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;     // 100 ns period
        end
    end

endmodule

// ==== testbench/cpu_assert.sv ====
`timescale 1ns/1ps

module cpu_assert
    import cpu_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  stall,
    input logic  redirect,
    input word_t target,
    input word_t pc
);

    // PC holds while decode stalls
    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        (stall && !redirect) |=> $stable(pc))
        else $error("PC moved during a stall");

    a_redirect_pc: assert property (@(posedge clk) disable iff (reset)
        redirect |=> (pc == $past(target)))
        else $error("PC does not match the redirect target");

    // Pipeline comes out of reset empty
    a_reset_exit: assert property (@(posedge clk)
        $fell(reset) |-> (!stall && !redirect))
        else $error("stall or redirect high right after reset");

endmodule

bind fetch_stage cpu_assert u_assert (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .redirect (redirect),
    .target   (target),
    .pc       (pc)
);

// ==== testbench/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu
    import cpu_pkg::*;
();

    localparam int TIMEOUT = 2000;

    logic  clk;
    logic  reset;
    key_t  key;
    hex_t  hex;
    led_t  ledr;
    logic  model_ready;
    integer seed;

    word_t prog [IMEM_WORDS];   // Program image for the reference model
    logic  exp_is_led [$];
    word_t exp_val [$];

    clock_gen u_clock (.clk(clk));

    cpu_top DUT (
        .clk   (clk),
        .reset (reset),
        .key   (key),
        .hex   (hex),
        .ledr  (ledr)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t ns: %s is %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    // Instruction-set interpreter that records every visible hex and LED change
    task automatic run_model();
        word_t  r [16];
        word_t  dmem_m [int];
        word_t  pc;
        word_t  inst;
        word_t  a;
        word_t  b;
        word_t  imm;
        word_t  res;
        word_t  addr;
        word_t  npc;
        op1_t   o1;
        op2_t   o2;
        regno_t rd;
        regno_t rs;
        regno_t rt;
        hex_t   hex_m;
        led_t   led_m;
        logic   taken;
        logic   done;
        int     steps;
        for (int i = 0; i < 16; i++) begin
            r[i] = '0;
        end
        pc    = START_PC;
        hex_m = 24'hFEDEAD;
        led_m = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 10000) begin
            inst  = prog[pc[15:2]];
            o1    = inst[31:26];
            o2    = inst[25:18];
            rd    = inst[11:8];
            rs    = inst[7:4];
            rt    = inst[3:0];
            imm   = {{16{inst[23]}}, inst[23:8]};
            a     = r[rs];
            b     = r[rt];
            addr  = a + imm;
            npc   = pc + 32'd4;
            taken = 1'b0;
            case (o1)
                OP1_ALUR: begin
                    case (o2)
                        OP2_EQ:   res = (a == b) ? 32'd1 : 32'd0;
                        OP2_LT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        OP2_LE:   res = ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
                        OP2_NE:   res = (a != b) ? 32'd1 : 32'd0;
                        OP2_ADD:  res = a + b;
                        OP2_AND:  res = a & b;
                        OP2_OR:   res = a | b;
                        OP2_XOR:  res = a ^ b;
                        OP2_SUB:  res = a - b;
                        OP2_NAND: res = ~(a & b);
                        OP2_NOR:  res = ~(a | b);
                        OP2_NXOR: res = ~(a ^ b);
                        OP2_RSHF: res = $signed(a) >>> b;
                        OP2_LSHF: res = a << b;
                        default:  res = '0;
                    endcase
                    r[rd] = res;
                end
                OP1_ADDI: r[rt] = a + imm;
                OP1_ANDI: r[rt] = a & imm;
                OP1_ORI:  r[rt] = a | imm;
                OP1_XORI: r[rt] = a ^ imm;
                OP1_LW: begin
                    if (addr == ADDR_KEY) begin
                        r[rt] = {28'b0, ~key};
                    end else if (dmem_m.exists(int'(addr[15:2]))) begin
                        r[rt] = dmem_m[int'(addr[15:2])];
                    end else begin
                        r[rt] = '0;
                    end
                end
                OP1_SW: begin
                    if (addr == ADDR_HEX && hex_m != b[23:0]) begin
                        hex_m = b[23:0];
                        exp_is_led.push_back(1'b0);
                        exp_val.push_back({8'b0, hex_m});
                    end
                    if (addr == ADDR_LEDR && led_m != b[9:0]) begin
                        led_m = b[9:0];
                        exp_is_led.push_back(1'b1);
                        exp_val.push_back({22'b0, led_m});
                    end
                    dmem_m[int'(addr[15:2])] = b;
                end
                OP1_BEQ: taken = (a == b);
                OP1_BLT: taken = ($signed(a) < $signed(b));
                OP1_BLE: taken = ($signed(a) <= $signed(b));
                OP1_BNE: taken = (a != b);
                OP1_JAL: begin
                    npc   = a + (imm << 2);
                    r[rt] = pc + 32'd4;
                end
                default: ;
            endcase
            if (taken) begin
                npc = pc + 32'd4 + (imm << 2);
            end
            done  = taken && (npc == pc);   // Branch to itself ends the program
            r[0]  = '0;
            pc    = npc;
            steps = steps + 1;
        end
        if (!done) begin
            abort_run("Reference model never reached the final branch loop");
        end
    endtask

    // Reset, then one random key value
    initial begin
        seed        = 32'h076c_112e;
        reset       = 1'b1;
        key         = '0;
        model_ready = 1'b0;
        $readmemh("test.hex", prog);
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("hex after reset", {8'b0, hex}, 32'h00FE_DEAD);
        check_value("ledr after reset", {22'b0, ledr}, '0);
        @(posedge clk);
        key <= key_t'($random(seed));
        @(negedge clk);
        run_model();
        model_ready = 1'b1;
    end

    // Compare process
    initial begin
        hex_t prev_hex;
        led_t prev_led;
        int   n;
        n = 0;
        while (!model_ready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run("Timeout waiting for the reference model");
        end
        prev_hex = hex;
        prev_led = ledr;
        for (int i = 0; i < exp_val.size(); i++) begin
            n = 0;
            while (hex === prev_hex && ledr === prev_led) begin
                @(negedge clk);
                n++;
                if (n > TIMEOUT) begin
                    abort_run($sformatf("Timeout waiting for output change %0d", i));
                end
            end
            check_value("LED written", {31'b0, ledr !== prev_led}, {31'b0, exp_is_led[i]});
            if (exp_is_led[i]) begin
                check_value("ledr", {22'b0, ledr}, exp_val[i]);
            end else begin
                check_value("hex", {8'b0, hex}, exp_val[i]);
            end
            prev_hex = hex;
            prev_led = ledr;
        end
        // Nothing more may appear once the program sits in its end loop
        repeat (200) begin
            @(negedge clk);
            check_value("hex after end", {8'b0, hex}, {8'b0, prev_hex});
            check_value("ledr after end", {22'b0, ledr}, {22'b0, prev_led});
        end
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_top.sv
testbench/clock_gen.sv
testbench/cpu_assert.sv
testbench/tb_cpu.sv

// ==== Makefile ====
SIM  := obj_dir/Vtb_cpu
SRCS := $(wildcard rtl/*.sv testbench/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) vlog.f
	verilator --binary --timing --assert --top-module tb_cpu -f vlog.f -o Vtb_cpu

run: $(SIM) test.hex
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== test.hex ====
// One 32-bit instruction word per line, hex
// @40 is word address of PC 100, @58 of PC 160
@40
80123401
80FFFD02
00800312
68F00003
00240421
00C00524
00C40614
00980756
68F00007
9400F078
68F00008
68004001
48004009
68F00009
20000219
68F00000
68F00000
2C000119
3000580A
68F00000
68F00000
@58
68F0200A
48F0800B
68F0200B
24000121
68F00000
28000112
00A00C12
68F0000C
20FFFF00
